//--- common/expanderRegPkg.sv
// ----------------------------------------------------------
// Port expander register map, data and index widths
// and register reset values
// ----------------------------------------------------------
`default_nettype none

package expanderRegPkg;

    localparam int regByteWidth  = 8;
    localparam int regIndexWidth = 5;
    localparam int regCount      = 2 ** regIndexWidth;   // 32 slots

    typedef logic [regByteWidth-1:0]  regByteT;
    typedef logic [regIndexWidth-1:0] regIndexT;   // wraps at 32

    // direction registers, a one bit means input
    localparam regIndexT idxDirA  = 5'h00;
    localparam regIndexT idxDirB  = 5'h01;

    // readback of the pins
    localparam regIndexT idxGpioA = 5'h12;
    localparam regIndexT idxGpioB = 5'h13;

    // output latches
    localparam regIndexT idxLatA  = 5'h14;
    localparam regIndexT idxLatB  = 5'h15;

    // all pins come up as inputs
    localparam regByteT dirResetValue = '1;
    localparam regByteT regResetValue = '0;

endpackage

`default_nettype wire

//--- common/i2cBusPkg.sv
// ----------------------------------------------------------
// I2C slave bus types, fixed address base
// and the protocol FSM state encoding
// ----------------------------------------------------------
`default_nettype none

package i2cBusPkg;

    typedef logic [6:0] slaveAddrT;     // 7-bit device address
    typedef logic [2:0] strapT;         // low address bits from strap pins
    typedef logic [2:0] bitCountT;      // bit position inside a byte

    // upper four address bits are fixed
    localparam logic [3:0] addrBase = 4'b0100;

    typedef enum logic [3:0] {
        idle,           // waiting for a start
        getAddr,        // shifting in address and r/w bit
        sendAddrAck,    // driving the address acknowledge
        getIndex,       // shifting in register index
        sendIndexAck,   // driving ack for index or write byte
        recvBits,       // receiving write data
        sendBits,       // sending read data
        recvDataAck,    // master acks or nacks the read byte
        recvAckRelease  // waiting for master to let go of sda
    } engineStateT;

endpackage

`default_nettype wire

//--- common/i2cLineIf.sv
// ----------------------------------------------------------
// Sampled I2C line events from sampler to protocol FSM
// ----------------------------------------------------------
`default_nettype none

interface i2cLineIf;

    logic sclFall;      // one cycle, synchronized scl went low
    logic startSeen;    // level, held until scl is low
    logic stopSeen;     // one cycle, sda rose with scl high
    logic sdaLevel;     // synchronized bus data

    modport sampler (output sclFall, output startSeen, output stopSeen, output sdaLevel);

    modport engine (input sclFall, input startSeen, input stopSeen, input sdaLevel);

endinterface

`default_nettype wire

//--- common/regAccessIf.sv
// ----------------------------------------------------------
// Register access between protocol FSM and register file
// ----------------------------------------------------------
`default_nettype none

interface regAccessIf;
    import expanderRegPkg::*;

    regIndexT regIndex;     // current register pointer
    regByteT  writeData;
    logic     writeStrobe;  // single cycle, byte stored on this edge
    regByteT  readData;     // combinational from regIndex

    modport engine (output regIndex, output writeData, output writeStrobe, input readData);

    modport store (input regIndex, input writeData, input writeStrobe, output readData);

endinterface

`default_nettype wire

//--- i2cSlave/i2cLineSampler.sv
// ----------------------------------------------------------
// I2C line sampler: two-stage synchronizers for scl/sda,
// scl fall, start and stop detection
// ----------------------------------------------------------
`default_nettype none

module i2cLineSampler (
    input  wire      CLOCK,
    input  wire      res,
    input  wire      scl,
    input  wire      sdaIn,
    i2cLineIf.sampler line
);

    logic [1:0] sclSync;    // [0] is the first stage
    logic [1:0] sdaSync;
    logic       sclPrev;    // previous synchronized values for edge detect
    logic       sdaPrev;

    always_ff @(posedge CLOCK or posedge res) begin
        if (res) begin
            // idle bus lines float high
            sclSync        <= 2'b11;
            sdaSync        <= 2'b11;
            sclPrev        <= 1'b1;
            sdaPrev        <= 1'b1;
            line.sclFall   <= 1'b0;
            line.startSeen <= 1'b0;
            line.stopSeen  <= 1'b0;
            line.sdaLevel  <= 1'b1;
        end else begin
            sclSync <= {sclSync[0], scl};
            sdaSync <= {sdaSync[0], sdaIn};
            sclPrev <= sclSync[1];
            sdaPrev <= sdaSync[1];

            line.sclFall  <= sclPrev & ~sclSync[1];
            line.stopSeen <= sclPrev & sclSync[1] & ~sdaPrev & sdaSync[1];   // sda rises, scl high
            line.sdaLevel <= sdaSync[1];

            // start stays up until the fsm has seen the following scl fall
            if (!sclPrev) begin
                line.startSeen <= 1'b0;
            end else if (sclSync[1] & sdaPrev & ~sdaSync[1]) begin
                line.startSeen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- i2cSlave/i2cProtocolEngine.sv
// ----------------------------------------------------------
// I2C slave FSM: address match, index load, byte writes
// with auto increment and MSB-first reads
// ----------------------------------------------------------
`default_nettype none

module i2cProtocolEngine (
    input  wire              CLOCK,
    input  wire              res,
    input  wire i2cBusPkg::strapT strap,
    i2cLineIf.engine         line,
    regAccessIf.engine       regs,
    output logic             sdaOut
);
    import i2cBusPkg::*;

    engineStateT state;
    bitCountT    bitCnt;
    slaveAddrT   addrShift;
    slaveAddrT   ownAddr;
    logic        readMode;      // r/w bit of the current address byte

    assign ownAddr = {addrBase, strap};

    always_ff @(posedge CLOCK or posedge res) begin
        if (res) begin
            state             <= idle;
            sdaOut            <= 1'b1;
            bitCnt            <= '0;
            readMode          <= 1'b0;
            regs.regIndex     <= '0;
            regs.writeStrobe  <= 1'b0;
        end else begin
            regs.writeStrobe <= 1'b0;

            // byte was stored on this edge, move to the next slot
            if (regs.writeStrobe) begin
                regs.regIndex <= regs.regIndex + 1'b1;
            end

            if (line.stopSeen) begin
                sdaOut <= 1'b1;     // float the bus
                state  <= idle;
            end else if (state == recvAckRelease && line.sdaLevel) begin
                // master released its ack, put out the next byte's msb now
                sdaOut <= regs.readData[7];
                state  <= sendBits;
            end else if (line.sclFall) begin
                if (line.startSeen) begin
                    // start or repeated start, from any state
                    bitCnt <= '0;
                    sdaOut <= 1'b1;
                    state  <= getAddr;
                end else begin
                    case (state)
                        idle: begin
                        end

                        getAddr: begin
                            if (bitCnt != 3'd7) begin
                                addrShift <= {addrShift[5:0], line.sdaLevel};
                                bitCnt    <= bitCnt + 1'b1;
                            end else if (addrShift == ownAddr) begin
                                readMode <= line.sdaLevel;
                                sdaOut   <= 1'b0;       // ack our address
                                state    <= sendAddrAck;
                            end else begin
                                state <= idle;          // someone else's address
                            end
                        end

                        sendAddrAck: begin
                            if (readMode) begin
                                bitCnt <= 3'd6;
                                sdaOut <= regs.readData[7];
                                state  <= sendBits;
                            end else begin
                                bitCnt <= '0;
                                sdaOut <= 1'b1;
                                state  <= getIndex;
                            end
                        end

                        getIndex: begin
                            // only the low five of the eight bits are kept
                            regs.regIndex <= {regs.regIndex[3:0], line.sdaLevel};
                            bitCnt        <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                sdaOut <= 1'b0;
                                state  <= sendIndexAck;
                            end
                        end

                        sendIndexAck: begin
                            bitCnt <= '0;
                            sdaOut <= 1'b1;
                            state  <= recvBits;
                        end

                        recvBits: begin
                            regs.writeData <= {regs.writeData[6:0], line.sdaLevel};
                            bitCnt         <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                regs.writeStrobe <= 1'b1;   // whole byte lands at once
                                sdaOut           <= 1'b0;
                                state            <= sendIndexAck;
                            end
                        end

                        sendBits: begin
                            // bitCnt wraps to 7 once bit 0 is on the bus
                            if (bitCnt != 3'd7) begin
                                sdaOut <= regs.readData[bitCnt];
                                bitCnt <= bitCnt - 1'b1;
                            end else begin
                                regs.regIndex <= regs.regIndex + 1'b1;
                                sdaOut        <= 1'b1;  // let master drive its ack
                                state         <= recvDataAck;
                            end
                        end

                        recvDataAck: begin
                            if (line.sdaLevel) begin
                                state <= idle;          // nack ends the read
                            end else begin
                                bitCnt <= 3'd6;
                                state  <= recvAckRelease;
                            end
                        end

                        default: state <= idle;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the port expander testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tbPortExpander -Mdir obj_dir -o simPortExpander
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simPortExpander +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- src.f
common/i2cBusPkg.sv
common/expanderRegPkg.sv
common/i2cLineIf.sv
common/regAccessIf.sv
i2cSlave/i2cLineSampler.sv
i2cSlave/i2cProtocolEngine.sv
verilog/expanderRegFile.sv
verilog/portExpander.sv
test/tbClockGen.sv
test/portExpander_assert.sv
test/tbPortExpander.sv

//--- test/portExpander_assert.sv
// ----------------------------------------------------------
// Bound bus checks: sda only moves with scl low,
// sda released after a stop
// ----------------------------------------------------------
`default_nettype none

module portExpander_assert (
    input wire CLOCK,
    input wire res,
    input wire scl,
    input wire sdaIn,
    input wire sdaOut
);

    int         violations = 0;
    logic [3:0] sclLowCount;    // saturates at 15
    logic       sdaInPrev;
    logic [3:0] stopHist;       // one bit per cycle since a stop

    always_ff @(posedge CLOCK or posedge res) begin
        if (res) begin
            sclLowCount <= '0;
            sdaInPrev   <= 1'b1;
            stopHist    <= '0;
        end else begin
            if (scl) begin
                sclLowCount <= '0;
            end else if (sclLowCount != 4'hf) begin
                sclLowCount <= sclLowCount + 4'd1;
            end
            sdaInPrev <= sdaIn;
            stopHist  <= {stopHist[2:0], scl & sdaIn & ~sdaInPrev};
        end
    end

    sdaMovesWithSclLow: assert property (@(posedge CLOCK) disable iff (res)
        (sdaOut != $past(sdaOut)) |-> (sdaOut || sclLowCount >= 4'd3))
        else begin
            violations++;
            $error("sdaOut fell while scl was high or only just low");
        end

    sdaFreeAfterStop: assert property (@(posedge CLOCK) disable iff (res)
        (|stopHist) |-> sdaOut)
        else begin
            violations++;
            $error("sdaOut pulled low right after a stop");
        end

endmodule

bind portExpander portExpander_assert u_busAssert (
    .CLOCK  (CLOCK),
    .res    (res),
    .scl    (scl),
    .sdaIn  (sdaIn),
    .sdaOut (sdaOut)
);

`default_nettype wire

//--- test/tbClockGen.sv
// ----------------------------------------------------------
// Testbench clock source, period 100
// ----------------------------------------------------------
`default_nettype none

module tbClockGen (
    output logic CLOCK
);

    initial CLOCK = 1'b0;

    always #50 CLOCK = ~CLOCK;

endmodule

`default_nettype wire

//--- test/tbPortExpander.sv
// ----------------------------------------------------------
// Testbench top with I2C master tasks, directed checks,
// cycle timeout and result summary
// ----------------------------------------------------------
`default_nettype none

module tbPortExpander;
    import i2cBusPkg::*;
    import expanderRegPkg::*;

    localparam int cycleLimit = 20000;   // about 4200 cycles of bus traffic and a wide margin

    wire     CLOCK;
    logic    res;
    strapT   strap;
    logic    scl;
    logic    masterSda;
    wire     sdaOut;
    wire     sdaIn = masterSda & sdaOut;    // wired-AND bus
    regByteT portAIn, portBIn;
    regByteT portAOut, portBOut;

    int        errors = 0;
    int        cycles = 0;
    logic      watchNoAck = 1'b0;
    slaveAddrT ownAddr;
    regByteT   latA, latB, dirA, dirB, storeVal, rdA, rdB;
    regIndexT  storeIdx;
    logic      ack;

    tbClockGen i_clockGen (.CLOCK(CLOCK));

    portExpander i_portExpander (
        .CLOCK    (CLOCK),
        .res      (res),
        .strap    (strap),
        .scl      (scl),
        .sdaIn    (sdaIn),
        .sdaOut   (sdaOut),
        .portAIn  (portAIn),
        .portBIn  (portBIn),
        .portAOut (portAOut),
        .portBOut (portBOut)
    );

    task automatic waitCycles(input int n);
        repeat (n) @(negedge CLOCK);
    endtask

    // one bus bit that starts and ends with scl just pulled low
    task automatic clockBit(input logic b, output logic seen);
        waitCycles(4);
        masterSda = b;
        waitCycles(4);
        scl = 1'b1;
        waitCycles(4);
        seen = sdaIn;
        waitCycles(4);
        scl = 1'b0;
    endtask

    task automatic busStart();
        waitCycles(4);
        masterSda = 1'b1;
        waitCycles(4);
        scl = 1'b1;
        waitCycles(8);
        masterSda = 1'b0;
        waitCycles(8);
        scl = 1'b0;
    endtask

    task automatic busStop();
        waitCycles(4);
        masterSda = 1'b0;
        waitCycles(4);
        scl = 1'b1;
        waitCycles(8);
        masterSda = 1'b1;
        waitCycles(8);
    endtask

    task automatic sendByte(input regByteT b, output logic ackBit);
        logic dummy;
        for (int i = 7; i >= 0; i--) begin
            clockBit(b[i], dummy);
        end
        clockBit(1'b1, ackBit);
    endtask

    task automatic readByte(input logic nack, output regByteT d);
        logic dummy;
        for (int i = 7; i >= 0; i--) begin
            clockBit(1'b1, d[i]);
        end
        clockBit(nack, dummy);
    endtask

    task automatic expectAck(input logic ackBit, input string what);
        assert (ackBit === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t: no acknowledge on %s", $time, what);
        end
    endtask

    task automatic expectByte(input regByteT got, input regByteT exp, input string what);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // input mode bits give the pin and bit 7 reads 0 there
    function automatic regByteT gpioExpect(regByteT dir, regByteT pins, regByteT lat);
        regByteT r;
        for (int i = 0; i < 8; i++) begin
            if (dir[i]) begin
                r[i] = (i == 7) ? 1'b0 : pins[i];
            end else begin
                r[i] = lat[i];
            end
        end
        return r;
    endfunction

    always @(posedge CLOCK) begin
        if (watchNoAck) begin
            assert (sdaOut === 1'b1) else begin
                errors++;
                $display("[ERROR] %0t: sdaOut pulled low for a foreign address", $time);
            end
        end
    end

    always @(posedge CLOCK) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h71f4879d));
        res       = 1'b1;
        strap     = 3'b101;
        scl       = 1'b1;
        masterSda = 1'b1;
        portAIn   = '0;
        portBIn   = '0;
        ownAddr   = {addrBase, strap};
        waitCycles(3);
        res = 1'b0;
        waitCycles(4);

        // reset state
        assert (sdaOut === 1'b1) else begin
            errors++;
            $display("[ERROR] %0t: sdaOut not released after reset", $time);
        end
        expectByte(portAOut, 8'h00, "portAOut after reset");
        expectByte(portBOut, 8'h00, "portBOut after reset");

        // two-byte write from latch A on
        latA = regByteT'($urandom) & 8'h7f;     // msb low makes a late stop visible on sda
        latB = regByteT'($urandom);
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(idxLatA), ack);
        expectAck(ack, "latch index");
        sendByte(latA, ack);
        expectAck(ack, "latch A byte");
        sendByte(latB, ack);
        expectAck(ack, "latch B byte");
        busStop();
        expectByte(portAOut, latA, "portAOut");
        expectByte(portBOut, latB, "portBOut");

        // the slave must stay off the bus for a foreign address
        busStart();
        watchNoAck = 1'b1;
        sendByte({addrBase, strap ^ 3'b001, 1'b0}, ack);
        sendByte(regByteT'(idxLatA), ack);
        sendByte(~latA, ack);
        watchNoAck = 1'b0;
        busStop();
        expectByte(portAOut, latA, "portAOut after foreign write");
        expectByte(portBOut, latB, "portBOut after foreign write");

        // mixed directions and pin readback through repeated starts
        dirA    = regByteT'($urandom);
        dirB    = regByteT'($urandom);
        portAIn = regByteT'($urandom);
        portBIn = regByteT'($urandom);
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(idxDirA), ack);
        expectAck(ack, "direction index");
        sendByte(dirA, ack);
        expectAck(ack, "direction A");
        sendByte(dirB, ack);
        expectAck(ack, "direction B");
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(idxGpioA), ack);
        expectAck(ack, "gpio index");
        busStart();
        sendByte({ownAddr, 1'b1}, ack);
        expectAck(ack, "read address");
        readByte(1'b0, rdA);
        readByte(1'b0, rdB);    // acked, so the stop meets a pending read of latch A
        busStop();
        expectByte(rdA, gpioExpect(dirA, portAIn, latA), "gpio A readback");
        expectByte(rdB, gpioExpect(dirB, portBIn, latB), "gpio B readback");

        // plain register store read back after a stop and a new start
        storeIdx = regIndexT'(8'h02 + ($urandom % 16));
        storeVal = regByteT'($urandom);
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(storeIdx), ack);
        expectAck(ack, "store index");
        sendByte(storeVal, ack);
        expectAck(ack, "store byte");
        busStop();
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(storeIdx), ack);
        expectAck(ack, "store index");
        busStart();
        sendByte({ownAddr, 1'b1}, ack);
        expectAck(ack, "read address");
        readByte(1'b1, rdA);
        busStop();
        expectByte(rdA, storeVal, "stored register");

        // after the nack a fresh write still lands
        latB = latB ^ regByteT'($urandom | 1);     // always differs from the old latch
        busStart();
        sendByte({ownAddr, 1'b0}, ack);
        expectAck(ack, "write address");
        sendByte(regByteT'(idxLatB), ack);
        expectAck(ack, "latch B index");
        sendByte(latB, ack);
        expectAck(ack, "latch B byte");
        busStop();
        expectByte(portBOut, latB, "portBOut after nack");

        $display("errors: %0d testbench checks, %0d bus assertions",
                 errors, i_portExpander.u_busAssert.violations);
        if (errors == 0 && i_portExpander.u_busAssert.violations == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/expanderRegFile.sv
// ----------------------------------------------------------
// Register file: 32 byte slots, port output latches
// and GPIO readback mux
// ----------------------------------------------------------
`default_nettype none

module expanderRegFile (
    input  wire                          CLOCK,
    input  wire                          res,
    regAccessIf.store                    regs,
    input  wire expanderRegPkg::regByteT portAIn,
    input  wire expanderRegPkg::regByteT portBIn,
    output expanderRegPkg::regByteT      portAOut,
    output expanderRegPkg::regByteT      portBOut
);
    import expanderRegPkg::*;

    regByteT regStore [regCount];

    // input mode bits follow the pin, output mode bits the latch
    function automatic regByteT pinReadback(regByteT dir, regByteT pins, regByteT latch);
        regByteT value;
        value    = (dir & pins) | (~dir & latch);
        value[7] = dir[7] ? 1'b0 : latch[7];   // bit 7 has no input pin
        return value;
    endfunction

    always_ff @(posedge CLOCK or posedge res) begin
        if (res) begin
            for (int i = 0; i < regCount; i++) begin
                if (i == idxDirA || i == idxDirB) begin
                    regStore[i] <= dirResetValue;
                end else begin
                    regStore[i] <= regResetValue;
                end
            end
        end else if (regs.writeStrobe) begin
            regStore[regs.regIndex] <= regs.writeData;
        end
    end

    assign portAOut = regStore[idxLatA];
    assign portBOut = regStore[idxLatB];

    always_comb begin
        case (regs.regIndex)
            idxGpioA: regs.readData = pinReadback(regStore[idxDirA], portAIn, regStore[idxLatA]);
            idxGpioB: regs.readData = pinReadback(regStore[idxDirB], portBIn, regStore[idxLatB]);
            default:  regs.readData = regStore[regs.regIndex];
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/portExpander.sv
// ----------------------------------------------------------
// I2C port expander top: line sampler, protocol FSM
// and register file on plain ports
// ----------------------------------------------------------
`default_nettype none

module portExpander (
    input  wire                          CLOCK,
    input  wire                          res,
    input  wire i2cBusPkg::strapT        strap,
    input  wire                          scl,
    input  wire                          sdaIn,     // bus level
    output logic                         sdaOut,    // open drain, low pulls the bus
    input  wire expanderRegPkg::regByteT portAIn,
    input  wire expanderRegPkg::regByteT portBIn,
    output expanderRegPkg::regByteT      portAOut,
    output expanderRegPkg::regByteT      portBOut
);

    i2cLineIf   lineBus ();
    regAccessIf regBus ();

    i2cLineSampler i_lineSampler (
        .CLOCK (CLOCK),
        .res   (res),
        .scl   (scl),
        .sdaIn (sdaIn),
        .line  (lineBus)
    );

    i2cProtocolEngine i_protocolEngine (
        .CLOCK  (CLOCK),
        .res    (res),
        .strap  (strap),
        .line   (lineBus),
        .regs   (regBus),
        .sdaOut (sdaOut)
    );

    expanderRegFile i_regFile (
        .CLOCK    (CLOCK),
        .res      (res),
        .regs     (regBus),
        .portAIn  (portAIn),
        .portBIn  (portBIn),
        .portAOut (portAOut),
        .portBOut (portBOut)
    );

endmodule

`default_nettype wire
